// File: hw/spu_odd_pkg.sv
`default_nettype none

package spu_odd_pkg;

    localparam int BYTE_W = 8;
    localparam int HALF_W = 16;
    localparam int WORD_W = 32;
    localparam int QUAD_W = 128;

    // bit 0 is the most significant bit in every vector type
    typedef logic [0:QUAD_W-1] quad_t;
    typedef logic [0:WORD_W-1] word_t;
    typedef logic [0:6]        reg_addr_t;
    typedef logic [0:6]        imm7_t;
    typedef logic [0:15]       imm16_t;

    // local store is 256 KB, every PC wraps inside it
    localparam word_t LSLR = 32'h0003_FFFF;

    typedef enum logic [0:4] {
        NOP     = 5'd0,
        // permute unit
        SHLQBI  = 5'd1,
        SHLQBII = 5'd2,
        SHLQBY  = 5'd3,
        SHLQBYI = 5'd4,
        ROTQBI  = 5'd5,
        ROTQBII = 5'd6,
        ROTQBY  = 5'd7,
        ROTQBYI = 5'd8,
        GBB     = 5'd9,
        GBH     = 5'd10,
        GB      = 5'd11,
        // branch unit
        BR      = 5'd12,
        BRA     = 5'd13,
        BRSL    = 5'd14,
        BRASL   = 5'd15,
        BRZ     = 5'd16,
        BRNZ    = 5'd17,
        BRHZ    = 5'd18,
        BRHNZ   = 5'd19
    } op_t;

endpackage

`default_nettype wire

// File: hw/permute_unit.sv
`default_nettype none

module permute_unit (
    input  spu_odd_pkg::op_t    op,
    input  spu_odd_pkg::quad_t  ra,
    input  spu_odd_pkg::quad_t  rb,
    input  spu_odd_pkg::imm7_t  imm7,
    output spu_odd_pkg::quad_t  result
);
    import spu_odd_pkg::*;

    logic        use_imm;
    logic [0:2]  bit_amt;
    logic [0:4]  byte_shl_amt;
    logic [0:3]  byte_rot_amt;
    logic [0:15] gather_b;
    logic [0:7]  gather_h;
    logic [0:3]  gather_w;

    // left rotate toward bit 0
    function automatic quad_t rotl(input quad_t value, input int unsigned amount);
        rotl = (value << amount) | (value >> (QUAD_W - amount));
    endfunction

    assign use_imm = (op == SHLQBII) || (op == SHLQBYI) ||
                     (op == ROTQBII) || (op == ROTQBYI);

    // counts from the low bits of rb's preferred word or of the immediate
    assign bit_amt      = use_imm ? imm7[4:6] : rb[WORD_W-3:WORD_W-1];
    assign byte_shl_amt = use_imm ? imm7[2:6] : rb[WORD_W-5:WORD_W-1];
    assign byte_rot_amt = use_imm ? imm7[3:6] : rb[WORD_W-4:WORD_W-1];

    // lsb of each element with element 0 first
    always_comb
    begin
        for (int j = 0; j < QUAD_W / BYTE_W; j++)
            gather_b[j] = ra[j * BYTE_W + BYTE_W - 1];
        for (int j = 0; j < QUAD_W / HALF_W; j++)
            gather_h[j] = ra[j * HALF_W + HALF_W - 1];
        for (int j = 0; j < QUAD_W / WORD_W; j++)
            gather_w[j] = ra[j * WORD_W + WORD_W - 1];
    end

    always_comb
    begin
        result = '0;
        case (op)
            SHLQBI, SHLQBII:
                result = ra << bit_amt;
            // 16 bytes or more shifts everything out
            SHLQBY, SHLQBYI:
                result = ra << {byte_shl_amt, 3'b000};
            ROTQBI, ROTQBII:
                result = rotl(ra, 32'(bit_amt));
            ROTQBY, ROTQBYI:
                result = rotl(ra, 32'({byte_rot_amt, 3'b000}));
            GBB:
                result[0:WORD_W-1] = {16'd0, gather_b};
            GBH:
                result[0:WORD_W-1] = {24'd0, gather_h};
            GB:
                result[0:WORD_W-1] = {28'd0, gather_w};
            default:
                result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`default_nettype none

module branch_unit (
    input  spu_odd_pkg::op_t     op,
    input  spu_odd_pkg::word_t   ra_word,
    input  spu_odd_pkg::word_t   pc,
    input  spu_odd_pkg::imm16_t  imm16,
    output logic                 taken,
    output spu_odd_pkg::word_t   target,
    output spu_odd_pkg::quad_t   link
);
    import spu_odd_pkg::*;

    word_t offset;
    word_t next_pc;
    word_t dest;
    logic  word_zero;
    logic  half_zero;

    // word offset, sign extended
    assign offset    = {{14{imm16[0]}}, imm16, 2'b00};
    assign next_pc   = pc + 32'd4;
    assign word_zero = (ra_word == '0);
    assign half_zero = (ra_word[HALF_W:WORD_W-1] == '0);

    always_comb
    begin
        taken = 1'b0;
        dest  = pc + offset;
        case (op)
            BR, BRSL:
                taken = 1'b1;
            BRA, BRASL:
            begin
                taken = 1'b1;
                dest  = offset;
            end
            BRZ:
                taken = word_zero;
            BRNZ:
                taken = ~word_zero;
            BRHZ:
                taken = half_zero;
            BRHNZ:
                taken = ~half_zero;
            default:
                taken = 1'b0;
        endcase
    end

    // falls through to the next instruction when not taken
    assign target = (taken ? dest : next_pc) & LSLR & 32'hFFFF_FFFC;

    // return address lands in the preferred word
    assign link = {next_pc & LSLR, {(QUAD_W - WORD_W){1'b0}}};

endmodule

`default_nettype wire

// File: hw/odd_issue_ctrl.sv
`default_nettype none

module odd_issue_ctrl #(
    parameter int PIPE_DEPTH = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  spu_odd_pkg::op_t      op,
    input  spu_odd_pkg::quad_t    ra,
    input  spu_odd_pkg::quad_t    rb,
    input  spu_odd_pkg::reg_addr_t rt_addr,
    input  spu_odd_pkg::imm7_t    imm7,
    input  spu_odd_pkg::imm16_t   imm16,
    input  spu_odd_pkg::word_t    pc,
    input  logic                  out_ready,
    input  spu_odd_pkg::quad_t    perm_data,
    input  logic                  br_taken,
    input  spu_odd_pkg::word_t    br_target,
    input  spu_odd_pkg::quad_t    br_link,
    output logic                  in_ready,
    output logic                  out_valid,
    output logic                  advance,
    output spu_odd_pkg::op_t      cur_op,
    output spu_odd_pkg::quad_t    cur_ra,
    output spu_odd_pkg::quad_t    cur_rb,
    output spu_odd_pkg::imm7_t    cur_imm7,
    output spu_odd_pkg::imm16_t   cur_imm16,
    output spu_odd_pkg::word_t    cur_pc,
    output spu_odd_pkg::quad_t    s1_data,
    output spu_odd_pkg::reg_addr_t s1_addr,
    output logic                  s1_wen,
    output logic                  s1_taken,
    output spu_odd_pkg::word_t    s1_target
);
    import spu_odd_pkg::*;

    // one valid bit per stage, index 0 is the operand register
    logic [0:PIPE_DEPTH-1] valid_q;
    reg_addr_t             cur_rt_addr;
    logic                  is_perm;
    logic                  is_link;

    // everything moves together unless a finished result is waiting
    assign advance   = out_ready | ~out_valid;
    assign in_ready  = advance;
    assign out_valid = valid_q[PIPE_DEPTH-1];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            valid_q <= '0;
        end
        else if (advance)
        begin
            valid_q <= {in_valid, valid_q[0:PIPE_DEPTH-2]};
        end
    end

    always_ff @(posedge clock)
    begin
        if (advance)
        begin
            cur_op      <= op;
            cur_ra      <= ra;
            cur_rb      <= rb;
            cur_rt_addr <= rt_addr;
            cur_imm7    <= imm7;
            cur_imm16   <= imm16;
            cur_pc      <= pc;
        end
    end

    // opcode class of the instruction in the operand register
    always_comb
    begin
        is_perm = 1'b0;
        is_link = 1'b0;
        case (cur_op)
            SHLQBI, SHLQBII, SHLQBY, SHLQBYI,
            ROTQBI, ROTQBII, ROTQBY, ROTQBYI,
            GBB, GBH, GB:
                is_perm = 1'b1;
            BRSL, BRASL:
                is_link = 1'b1;
            default:
                is_perm = 1'b0;
        endcase
    end

    // plain branches and NOP write nothing, an empty slot writes nothing either
    assign s1_wen    = valid_q[0] & (is_perm | is_link);
    assign s1_taken  = valid_q[0] & br_taken;
    assign s1_addr   = cur_rt_addr;
    assign s1_target = br_target;
    assign s1_data   = is_perm ? perm_data : (is_link ? br_link : '0);

endmodule

`default_nettype wire

// File: hw/odd_result_pipe.sv
`default_nettype none

module odd_result_pipe #(
    parameter int PIPE_DEPTH = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   advance,
    input  spu_odd_pkg::quad_t     s1_data,
    input  spu_odd_pkg::reg_addr_t s1_addr,
    input  logic                   s1_wen,
    input  logic                   s1_taken,
    input  spu_odd_pkg::word_t     s1_target,
    output spu_odd_pkg::quad_t     wb_data,
    output spu_odd_pkg::reg_addr_t wb_addr,
    output logic                   wb_en,
    output logic                   branch_taken,
    output spu_odd_pkg::word_t     branch_target
);
    import spu_odd_pkg::*;

    // the operand register in the issue control is the first stage
    localparam int STAGES = PIPE_DEPTH - 1;

    quad_t             data_q   [STAGES];
    reg_addr_t         addr_q   [STAGES];
    word_t             target_q [STAGES];
    logic [0:STAGES-1] wen_q;
    logic [0:STAGES-1] taken_q;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wen_q   <= '0;
            taken_q <= '0;
        end
        else if (advance)
        begin
            wen_q[0]   <= s1_wen;
            taken_q[0] <= s1_taken;
            for (int i = 1; i < STAGES; i++)
            begin
                wen_q[i]   <= wen_q[i-1];
                taken_q[i] <= taken_q[i-1];
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (advance)
        begin
            data_q[0]   <= s1_data;
            addr_q[0]   <= s1_addr;
            target_q[0] <= s1_target;
            for (int i = 1; i < STAGES; i++)
            begin
                data_q[i]   <= data_q[i-1];
                addr_q[i]   <= addr_q[i-1];
                target_q[i] <= target_q[i-1];
            end
        end
    end

    // last stage feeds the register file write port
    assign wb_data       = data_q[STAGES-1];
    assign wb_addr       = addr_q[STAGES-1];
    assign wb_en         = wen_q[STAGES-1];
    assign branch_taken  = taken_q[STAGES-1];
    assign branch_target = target_q[STAGES-1];

endmodule

`default_nettype wire

// File: hw/odd_pipe_top.sv
`default_nettype none

module odd_pipe_top #(
    parameter int PIPE_DEPTH = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    input  spu_odd_pkg::op_t       op,
    input  spu_odd_pkg::quad_t     ra,
    input  spu_odd_pkg::quad_t     rb,
    input  spu_odd_pkg::reg_addr_t rt_addr,
    input  spu_odd_pkg::imm7_t     imm7,
    input  spu_odd_pkg::imm16_t    imm16,
    input  spu_odd_pkg::word_t     pc,
    input  logic                   out_ready,
    output logic                   in_ready,
    output logic                   out_valid,
    output spu_odd_pkg::quad_t     wb_data,
    output spu_odd_pkg::reg_addr_t wb_addr,
    output logic                   wb_en,
    output logic                   branch_taken,
    output spu_odd_pkg::word_t     branch_target
);
    import spu_odd_pkg::*;

    logic      advance;
    op_t       cur_op;
    quad_t     cur_ra;
    quad_t     cur_rb;
    imm7_t     cur_imm7;
    imm16_t    cur_imm16;
    word_t     cur_pc;
    quad_t     perm_data;
    logic      br_taken;
    word_t     br_target;
    quad_t     br_link;
    quad_t     s1_data;
    reg_addr_t s1_addr;
    logic      s1_wen;
    logic      s1_taken;
    word_t     s1_target;

    odd_issue_ctrl #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_issue_ctrl (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .op        (op),
        .ra        (ra),
        .rb        (rb),
        .rt_addr   (rt_addr),
        .imm7      (imm7),
        .imm16     (imm16),
        .pc        (pc),
        .out_ready (out_ready),
        .perm_data (perm_data),
        .br_taken  (br_taken),
        .br_target (br_target),
        .br_link   (br_link),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .advance   (advance),
        .cur_op    (cur_op),
        .cur_ra    (cur_ra),
        .cur_rb    (cur_rb),
        .cur_imm7  (cur_imm7),
        .cur_imm16 (cur_imm16),
        .cur_pc    (cur_pc),
        .s1_data   (s1_data),
        .s1_addr   (s1_addr),
        .s1_wen    (s1_wen),
        .s1_taken  (s1_taken),
        .s1_target (s1_target)
    );

    permute_unit u_permute_unit (
        .op     (cur_op),
        .ra     (cur_ra),
        .rb     (cur_rb),
        .imm7   (cur_imm7),
        .result (perm_data)
    );

    // conditionals test the preferred word of ra
    branch_unit u_branch_unit (
        .op      (cur_op),
        .ra_word (cur_ra[0:WORD_W-1]),
        .pc      (cur_pc),
        .imm16   (cur_imm16),
        .taken   (br_taken),
        .target  (br_target),
        .link    (br_link)
    );

    odd_result_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_result_pipe (
        .clock         (clock),
        .reset         (reset),
        .advance       (advance),
        .s1_data       (s1_data),
        .s1_addr       (s1_addr),
        .s1_wen        (s1_wen),
        .s1_taken      (s1_taken),
        .s1_target     (s1_target),
        .wb_data       (wb_data),
        .wb_addr       (wb_addr),
        .wb_en         (wb_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

`default_nettype wire

// File: verif/odd_pipe_properties.sv
`default_nettype none

module odd_pipe_properties (
    input logic                   clock,
    input logic                   reset,
    input logic                   in_ready,
    input logic                   out_valid,
    input logic                   out_ready,
    input spu_odd_pkg::quad_t     wb_data,
    input spu_odd_pkg::reg_addr_t wb_addr,
    input logic                   wb_en,
    input logic                   branch_taken,
    input spu_odd_pkg::word_t     branch_target
);
    timeunit 1ns;
    timeprecision 1ps;

    // the input side opens whenever the output side can move
    ready_follows_advance: assert property (@(posedge clock) disable iff (reset)
        in_ready == (out_ready || !out_valid))
        else $error("in_ready differs from out_ready or an idle output");

    // a stalled result keeps every output field
    hold_while_stalled: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(wb_data) && $stable(wb_addr)
        && $stable(wb_en) && $stable(branch_taken) && $stable(branch_target))
        else $error("outputs changed while the result was stalled");

    reset_clears_outputs: assert property (@(posedge clock)
        reset |=> !out_valid && !wb_en && !branch_taken && in_ready)
        else $error("output side not idle after reset");

endmodule

bind odd_pipe_top odd_pipe_properties u_properties (
    .clock         (clock),
    .reset         (reset),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .wb_data       (wb_data),
    .wb_addr       (wb_addr),
    .wb_en         (wb_en),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
);

`default_nettype wire

// File: verif/odd_pipe_tb.sv
`default_nettype none

module odd_pipe_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import spu_odd_pkg::*;

    localparam int PIPE_DEPTH = 4;
    localparam int N_INSTR = 130;
    // four clock periods per instruction plus slack
    localparam int WATCHDOG_NS = (N_INSTR + PIPE_DEPTH) * 4 * 40 + 2000;

    logic      clock = 1'b0;
    logic      reset;
    logic      in_valid;
    op_t       op;
    quad_t     ra;
    quad_t     rb;
    reg_addr_t rt_addr;
    imm7_t     imm7;
    imm16_t    imm16;
    word_t     pc;
    logic      out_ready = 1'b1;
    logic      in_ready;
    logic      out_valid;
    quad_t     wb_data;
    reg_addr_t wb_addr;
    logic      wb_en;
    logic      branch_taken;
    word_t     branch_target;

    // expected results in acceptance order
    quad_t     q_data [$];
    reg_addr_t q_addr [$];
    logic      q_wen [$];
    logic      q_taken [$];
    word_t     q_target [$];
    logic      q_branch [$];
    int        q_edge [$];
    int        q_stall [$];

    int   value_errors = 0;
    int   other_errors = 0;
    int   edge_cnt = 0;
    int   stall_cnt = 0;
    logic random_ready;

    odd_pipe_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_dut (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .op            (op),
        .ra            (ra),
        .rb            (rb),
        .rt_addr       (rt_addr),
        .imm7          (imm7),
        .imm16         (imm16),
        .pc            (pc),
        .out_ready     (out_ready),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .wb_data       (wb_data),
        .wb_addr       (wb_addr),
        .wb_en         (wb_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always #20 clock = ~clock;

    // move data toward bit 0 by amt bits with optional wrap
    function automatic quad_t shift_quad(input quad_t a, input int amt, input logic wrap);
        quad_t r;
        r = '0;
        for (int i = 0; i < QUAD_W; i++)
        begin
            if (wrap)
                r[i] = a[(i + amt) % QUAD_W];
            else if (i + amt < QUAD_W)
                r[i] = a[i + amt];
        end
        return r;
    endfunction

    function automatic quad_t expect_perm(input op_t f_op, input quad_t a, input quad_t b,
                                          input imm7_t i7);
        quad_t       r;
        logic [31:0] cnt;
        r = '0;
        if (f_op inside {SHLQBII, SHLQBYI, ROTQBII, ROTQBYI})
            cnt = {25'd0, i7};
        else
            cnt = b[0:WORD_W-1];
        case (f_op)
            SHLQBI, SHLQBII:
                r = shift_quad(a, int'(cnt % 8), 1'b0);
            SHLQBY, SHLQBYI:
                r = shift_quad(a, int'(cnt % 32) * 8, 1'b0);
            ROTQBI, ROTQBII:
                r = shift_quad(a, int'(cnt % 8), 1'b1);
            ROTQBY, ROTQBYI:
                r = shift_quad(a, int'(cnt % 16) * 8, 1'b1);
            GBB:
                for (int j = 0; j < 16; j++)
                    r[16 + j] = a[8 * j + 7];
            GBH:
                for (int j = 0; j < 8; j++)
                    r[24 + j] = a[16 * j + 15];
            GB:
                for (int j = 0; j < 4; j++)
                    r[28 + j] = a[32 * j + 31];
            default:
                r = '0;
        endcase
        return r;
    endfunction

    task automatic expect_branch(input op_t f_op, input word_t ra_w, input word_t pc_v,
                                 input imm16_t i16, output logic tk, output word_t tgt,
                                 output quad_t lnk);
        word_t off;
        word_t dest;
        off  = {{16{i16[0]}}, i16} * 32'd4;
        dest = pc_v + off;
        tk   = 1'b0;
        case (f_op)
            BR, BRSL:
                tk = 1'b1;
            BRA, BRASL:
            begin
                tk   = 1'b1;
                dest = off;
            end
            BRZ:
                tk = (ra_w == 32'd0);
            BRNZ:
                tk = (ra_w != 32'd0);
            BRHZ:
                tk = (ra_w[16:31] == 16'd0);
            BRHNZ:
                tk = (ra_w[16:31] != 16'd0);
            default:
                tk = 1'b0;
        endcase
        if (!tk)
            dest = pc_v + 32'd4;
        tgt = dest & LSLR & ~32'd3;
        lnk = '0;
        lnk[0:WORD_W-1] = (pc_v + 32'd4) & LSLR;
    endtask

    task automatic push_expected();
        quad_t perm;
        quad_t lnk;
        logic  tk;
        word_t tgt;
        logic  is_perm;
        logic  is_link;
        is_perm = op inside {SHLQBI, SHLQBII, SHLQBY, SHLQBYI, ROTQBI, ROTQBII,
                             ROTQBY, ROTQBYI, GBB, GBH, GB};
        is_link = op inside {BRSL, BRASL};
        perm = expect_perm(op, ra, rb, imm7);
        expect_branch(op, ra[0:WORD_W-1], pc, imm16, tk, tgt, lnk);
        q_data.push_back(is_perm ? perm : lnk);
        q_addr.push_back(rt_addr);
        q_wen.push_back(is_perm || is_link);
        q_taken.push_back(tk);
        q_target.push_back(tgt);
        q_branch.push_back(op inside {BR, BRA, BRSL, BRASL, BRZ, BRNZ, BRHZ, BRHNZ});
        q_edge.push_back(edge_cnt);
        q_stall.push_back(stall_cnt);
    endtask

    task automatic mismatch(input string field, input string got, input string want);
        $display("ERR %0t: %s is %s, expected %s", $time, field, got, want);
        value_errors++;
    endtask

    task automatic check_result();
        quad_t     e_data;
        reg_addr_t e_addr;
        logic      e_wen;
        logic      e_taken;
        word_t     e_target;
        logic      e_branch;
        int        latency;
        int        e_latency;
        if (q_wen.size() == 0)
        begin
            $display("result at %0t arrived with no instruction outstanding", $time);
            other_errors++;
            return;
        end
        e_data    = q_data.pop_front();
        e_addr    = q_addr.pop_front();
        e_wen     = q_wen.pop_front();
        e_taken   = q_taken.pop_front();
        e_target  = q_target.pop_front();
        e_branch  = q_branch.pop_front();
        latency   = edge_cnt - q_edge.pop_front();
        // every stall cycle in between delays the result by one
        e_latency = PIPE_DEPTH + stall_cnt - q_stall.pop_front();
        assert (wb_en == e_wen)
            else mismatch("wb_en", $sformatf("%b", wb_en), $sformatf("%b", e_wen));
        assert (branch_taken == e_taken)
            else mismatch("branch_taken", $sformatf("%b", branch_taken), $sformatf("%b", e_taken));
        assert (latency == e_latency)
            else mismatch("latency", $sformatf("%0d", latency), $sformatf("%0d", e_latency));
        if (e_wen)
        begin
            assert (wb_addr == e_addr)
                else mismatch("wb_addr", $sformatf("%h", wb_addr), $sformatf("%h", e_addr));
            assert (wb_data == e_data)
                else mismatch("wb_data", $sformatf("%h", wb_data), $sformatf("%h", e_data));
        end
        if (e_branch)
        begin
            assert (branch_target == e_target)
                else mismatch("branch_target", $sformatf("%h", branch_target),
                              $sformatf("%h", e_target));
        end
    endtask

    // scoreboard sampled on the edge where both handshakes are decided
    always @(posedge clock)
    begin
        if (!reset && out_valid && out_ready)
            check_result();
        if (!reset && in_valid && in_ready)
            push_expected();
        if (!reset && out_valid && !out_ready)
            stall_cnt++;
        edge_cnt++;
    end

    always @(posedge clock)
    begin
        if (random_ready)
            out_ready <= ($urandom % 2) == 0;
        else
            out_ready <= 1'b1;
    end

    function automatic quad_t rand_quad();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic op_t rand_op();
        return op_t'(5'($urandom % 20));
    endfunction

    // drive one instruction and return right after the edge that accepts it
    task automatic send(input op_t o, input quad_t a, input quad_t b, input imm7_t i7,
                        input imm16_t i16, input word_t p);
        logic [31:0] r;
        r = $urandom;
        in_valid <= 1'b1;
        op       <= o;
        ra       <= a;
        rb       <= b;
        rt_addr  <= r[6:0];
        imm7     <= i7;
        imm16    <= i16;
        pc       <= p;
        @(posedge clock);
        while (!in_ready)
            @(posedge clock);
    endtask

    task automatic send_random(input op_t o);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $urandom;
        r2 = $urandom;
        send(o, rand_quad(), rand_quad(), r1[6:0], r1[31:16], r2);
    endtask

    initial
    begin
        op_t   shift_ops [8];
        op_t   jump_ops [4];
        op_t   cond_ops [4];
        int    amounts [3];
        quad_t a;
        quad_t b;
        void'($urandom(67));
        shift_ops = '{SHLQBI, SHLQBII, SHLQBY, SHLQBYI, ROTQBI, ROTQBII, ROTQBY, ROTQBYI};
        jump_ops  = '{BR, BRA, BRSL, BRASL};
        cond_ops  = '{BRZ, BRNZ, BRHZ, BRHNZ};
        amounts   = '{15, 16, 31};
        reset        <= 1'b1;
        in_valid     <= 1'b0;
        op           <= NOP;
        ra           <= '0;
        rb           <= '0;
        rt_addr      <= '0;
        imm7         <= '0;
        imm16        <= '0;
        pc           <= '0;
        random_ready <= 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        // back to back with the output always ready
        for (int k = 0; k < 8; k++)
            repeat (4) send_random(shift_ops[k]);
        for (int k = 0; k < 3; k++)
        begin
            b = rand_quad();
            b[0:WORD_W-1] = 32'(amounts[k]);
            send(SHLQBY, rand_quad(), b, 7'd0, 16'd0, $urandom);
            send(SHLQBYI, rand_quad(), rand_quad(), 7'(amounts[k]), 16'd0, $urandom);
        end
        repeat (3)
        begin
            send_random(GBB);
            send_random(GBH);
            send_random(GB);
        end
        for (int k = 0; k < 4; k++)
        begin
            send(jump_ops[k], rand_quad(), rand_quad(), 7'd0, 16'hFFF0, $urandom);
            send(jump_ops[k], rand_quad(), rand_quad(), 7'd0, 16'h0123, $urandom);
        end
        for (int k = 0; k < 4; k++)
        begin
            a = rand_quad();
            a[0:WORD_W-1] = 32'd0;
            send(cond_ops[k], a, rand_quad(), 7'd0, 16'h0040, $urandom);
            a[0:WORD_W-1] = 32'h5A5A_0000;
            send(cond_ops[k], a, rand_quad(), 7'd0, 16'hFF80, $urandom);
            send_random(cond_ops[k]);
        end
        send_random(NOP);
        send_random(NOP);
        send_random(op_t'(5'd25));

        // random back-pressure with the odd idle cycle on the input
        random_ready <= 1'b1;
        repeat (60)
        begin
            if ($urandom % 4 == 0)
            begin
                in_valid <= 1'b0;
                @(posedge clock);
            end
            send_random(rand_op());
        end
        in_valid <= 1'b0;

        while (q_wen.size() != 0)
            @(posedge clock);
        repeat (4) @(posedge clock);
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run still going after %0d ns with %0d results outstanding",
                 WATCHDOG_NS, q_wen.size());
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hw/spu_odd_pkg.sv
hw/permute_unit.sv
hw/branch_unit.sv
hw/odd_issue_ctrl.sv
hw/odd_result_pipe.sv
hw/odd_pipe_top.sv
verif/odd_pipe_properties.sv
verif/odd_pipe_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module odd_pipe_tb \
    -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vodd_pipe_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
